// ==== vlog.f ====
+incdir+bench
logic/bus_pkg.sv
logic/soc_map_pkg.sv
logic/mem_if.sv
logic/bank_ram.sv
logic/banked_ram.sv
logic/heap_arbiter.sv
logic/led_port.sv
logic/region_decoder.sv
logic/soc_mem_top.sv
bench/tb_soc_mem.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_soc_mem
FILELIST  ?= vlog.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tb_soc_mem_checks.svh ====
// Byte models of both RAMs indexed by the 16-bit offset
logic [7:0] text_model [65536];
logic [7:0] heap_model [65536];
logic [3:0] led_model;

function automatic void model_write(input logic [31:0] addr, input logic [31:0] wdata,
                                    input logic [3:0] strb);
  logic [15:0] base;
  base = {addr[15:2], 2'b00};
  for (int i = 0; i < 4; i++) begin
    if (strb[i]) begin
      if (addr[31:16] == 16'h0000) begin
        text_model[base + 16'(i)] = wdata[8*i +: 8];
      end else if (addr[31:16] == 16'h0001) begin
        heap_model[base + 16'(i)] = wdata[8*i +: 8];
      end
    end
  end
  // Any strobe loads the whole LED field
  if (addr[31:16] == 16'h8001 && strb != 4'h0) begin
    led_model = wdata[3:0];
  end
endfunction

function automatic logic [31:0] model_read(input logic [31:0] addr);
  logic [15:0] base;
  logic [31:0] word;
  base = {addr[15:2], 2'b00};
  word = '0;
  for (int i = 0; i < 4; i++) begin
    if (addr[31:16] == 16'h0000) begin
      word[8*i +: 8] = text_model[base + 16'(i)];
    end else if (addr[31:16] == 16'h0001) begin
      word[8*i +: 8] = heap_model[base + 16'(i)];
    end
  end
  if (addr[31:16] == 16'h8001) begin
    word = {28'd0, led_model};
  end
  return word;
endfunction

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
  assert (got === exp) else begin
    $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
    $display("TEST FAILED");
    $fatal(1, "value mismatch");
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic got);
  assert (got === exp) else begin
    $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, got);
    $display("TEST FAILED");
    $fatal(1, "value mismatch");
  end
endtask

// ==== bench/tb_soc_mem.sv ====
`timescale 1ns/1ps

module tb_soc_mem;

  localparam logic [31:0] TEXT_BASE  = 32'h0000_0000;
  localparam logic [31:0] HEAP_BASE  = 32'h0001_0000;
  localparam logic [31:0] LED_ADDR   = 32'h8001_0000;
  localparam int          MAX_CYCLES = 4000;

  logic        clk;
  logic        resetn;
  logic        mem_valid;
  logic        mem_ready;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0]  mem_wstrb;
  logic [31:0] mem_rdata;
  logic        dma_req;
  logic        dma_grant;
  logic        dma_valid;
  logic        dma_ready;
  logic [31:0] dma_addr;
  logic [31:0] dma_wdata;
  logic [3:0]  dma_wstrb;
  logic [31:0] dma_rdata;
  logic [3:0]  led;

  int          cycle_count = 0;
  logic [31:0] addrs [8];
  logic [31:0] data;
  int          n;

  `include "tb_soc_mem_checks.svh"

  soc_mem_top UUT (
    .clk       (clk),
    .resetn    (resetn),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .dma_req   (dma_req),
    .dma_grant (dma_grant),
    .dma_valid (dma_valid),
    .dma_ready (dma_ready),
    .dma_addr  (dma_addr),
    .dma_wdata (dma_wdata),
    .dma_wstrb (dma_wstrb),
    .dma_rdata (dma_rdata),
    .led       (led)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the test sequence did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic apply_reset();
    resetn = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    resetn = 1'b1;
  endtask

  task automatic host_access(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] strb, input int exp_lat,
                             output logic [31:0] rdata);
    int cnt;
    @(posedge clk);
    #1;
    mem_valid = 1'b1;
    mem_addr  = addr;
    mem_wdata = wdata;
    mem_wstrb = strb;
    // Request edge
    @(posedge clk);
    cnt = 1;
    @(negedge clk);
    while (!mem_ready) begin
      @(negedge clk);
      cnt++;
    end
    rdata = mem_rdata;
    check_value("mem_ready latency", exp_lat, cnt);
    @(posedge clk);
    #1;
    // Ready must drop while valid is still held
    check_bit("mem_ready", 1'b0, mem_ready);
    mem_valid = 1'b0;
    mem_wstrb = '0;
  endtask

  task automatic dma_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, input int exp_lat,
                            output logic [31:0] rdata);
    int cnt;
    @(posedge clk);
    #1;
    dma_valid = 1'b1;
    dma_addr  = addr;
    dma_wdata = wdata;
    dma_wstrb = strb;
    @(posedge clk);
    cnt = 1;
    @(negedge clk);
    while (!dma_ready) begin
      @(negedge clk);
      cnt++;
    end
    rdata = dma_rdata;
    check_value("dma_ready latency", exp_lat, cnt);
    @(posedge clk);
    #1;
    check_bit("dma_ready", 1'b0, dma_ready);
    dma_valid = 1'b0;
    dma_wstrb = '0;
  endtask

  task automatic host_write(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb);
    logic [31:0] unused_rd;
    model_write(addr, wdata, strb);
    host_access(addr, wdata, strb, 1, unused_rd);
  endtask

  task automatic host_read_check(input logic [31:0] addr, input int exp_lat);
    logic [31:0] got;
    host_access(addr, $urandom, 4'h0, exp_lat, got);
    check_value("mem_rdata", model_read(addr), got);
  endtask

  task automatic dma_write(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] strb);
    logic [31:0] unused_rd;
    model_write(addr, wdata, strb);
    dma_access(addr, wdata, strb, 1, unused_rd);
  endtask

  task automatic dma_read_check(input logic [31:0] addr);
    logic [31:0] got;
    dma_access(addr, $urandom, 4'h0, 2, got);
    check_value("dma_rdata", model_read(addr), got);
  endtask

  initial begin
    void'($urandom(32'h22e6));
    resetn    = 1'b0;
    mem_valid = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    dma_req   = 1'b0;
    dma_valid = 1'b0;
    dma_addr  = '0;
    dma_wdata = '0;
    dma_wstrb = '0;
    led_model = '0;
    apply_reset();
    @(negedge clk);
    check_bit("mem_ready", 1'b0, mem_ready);
    check_bit("dma_ready", 1'b0, dma_ready);
    check_bit("dma_grant", 1'b0, dma_grant);
    check_value("led", 32'd0, {28'd0, led});

    // Memory keeps its contents across a reset
    host_write(TEXT_BASE | 32'h40, $urandom, 4'hf);
    apply_reset();
    host_read_check(TEXT_BASE | 32'h40, 2);

    // Full words first, then random strobes merged over them
    for (int i = 0; i < 8; i++) begin
      addrs[i] = 32'($urandom) & 32'h0000_fffc;
      host_write(TEXT_BASE | addrs[i], $urandom, 4'hf);
      host_write(HEAP_BASE | addrs[i], $urandom, 4'hf);
    end
    for (int i = 0; i < 8; i++) begin
      host_write(TEXT_BASE | addrs[i], $urandom, 4'($urandom_range(1, 15)));
      host_write(HEAP_BASE | addrs[i], $urandom, 4'($urandom_range(1, 15)));
    end
    for (int i = 0; i < 8; i++) begin
      host_read_check(TEXT_BASE | addrs[i], 2);
      host_read_check(HEAP_BASE | addrs[i], 2);
    end

    // Same word index in every bank of both RAMs
    for (int b = 0; b < 4; b++) begin
      host_write({16'h0000, 2'(b), 12'h123, 2'b00}, 32'ha5a5_0000 | 32'(b), 4'hf);
      host_write({16'h0001, 2'(b), 12'h123, 2'b00}, 32'h5a5a_0010 | 32'(b), 4'hf);
    end
    for (int b = 0; b < 4; b++) begin
      host_read_check({16'h0000, 2'(b), 12'h123, 2'b00}, 2);
      host_read_check({16'h0001, 2'(b), 12'h123, 2'b00}, 2);
    end

    // LED register
    for (int i = 0; i < 3; i++) begin
      data = $urandom;
      host_write(LED_ADDR, data, 4'hf);
      check_value("led", {28'd0, data[3:0]}, {28'd0, led});
      host_read_check(LED_ADDR, 1);
    end

    // Grant waits for the host heap read in flight
    @(posedge clk);
    #1;
    mem_valid = 1'b1;
    mem_addr  = HEAP_BASE | addrs[0];
    mem_wstrb = '0;
    dma_req   = 1'b1;
    @(negedge clk);
    while (!mem_ready) begin
      check_bit("dma_grant", 1'b0, dma_grant);
      @(negedge clk);
    end
    check_bit("dma_grant", 1'b0, dma_grant);
    check_value("mem_rdata", model_read(HEAP_BASE | addrs[0]), mem_rdata);
    @(posedge clk);
    #1;
    mem_valid = 1'b0;
    @(negedge clk);
    while (!dma_grant) begin
      @(negedge clk);
    end

    // Text path ignores DMA ownership
    host_write(TEXT_BASE | 32'h0200, $urandom, 4'($urandom_range(1, 15)));
    host_read_check(TEXT_BASE | 32'h0200, 2);
    dma_write(HEAP_BASE | 32'h0300, $urandom, 4'hf);
    dma_write(HEAP_BASE | 32'h0300, $urandom, 4'($urandom_range(1, 15)));
    dma_read_check(HEAP_BASE | addrs[1]);
    dma_read_check(HEAP_BASE | 32'h0300);

    // Host heap read stalls until the grant falls
    @(posedge clk);
    #1;
    mem_valid = 1'b1;
    mem_addr  = HEAP_BASE | 32'h0300;
    mem_wstrb = '0;
    repeat (4) begin
      @(negedge clk);
      check_bit("mem_ready", 1'b0, mem_ready);
    end
    @(posedge clk);
    #1;
    dma_req = 1'b0;
    @(negedge clk);
    check_bit("dma_grant", 1'b1, dma_grant);
    check_bit("mem_ready", 1'b0, mem_ready);
    @(negedge clk);
    check_bit("dma_grant", 1'b0, dma_grant);
    n = 1;
    while (!mem_ready) begin
      @(negedge clk);
      n++;
    end
    check_value("mem_ready latency after release", 32'd3, n);
    check_value("mem_rdata", model_read(HEAP_BASE | 32'h0300), mem_rdata);
    @(posedge clk);
    #1;
    mem_valid = 1'b0;
    host_read_check(HEAP_BASE | 32'h0300, 2);

    repeat (4) @(posedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== logic/soc_mem_top.sv ====
`timescale 1ns/1ps

module soc_mem_top
  import bus_pkg::*;
  import soc_map_pkg::*;
#(
  parameter int LED_W = LED_W_DEFAULT
) (
  input  logic             clk,
  input  logic             resetn,
  input  logic             mem_valid,
  output logic             mem_ready,
  input  addr_word_t       mem_addr,
  input  data_t            mem_wdata,
  input  strb_t            mem_wstrb,
  output data_t            mem_rdata,
  input  logic             dma_req,
  output logic             dma_grant,
  input  logic             dma_valid,
  output logic             dma_ready,
  input  addr_word_t       dma_addr,
  input  data_t            dma_wdata,
  input  strb_t            dma_wstrb,
  output data_t            dma_rdata,
  output logic [LED_W-1:0] led
);

  mem_if text_bus ();
  mem_if heap_bus ();
  mem_if led_bus ();
  mem_if heap_ram_bus ();

  region_decoder u_decoder (
    .host_valid (mem_valid),
    .host_ready (mem_ready),
    .host_addr  (mem_addr),
    .host_wdata (mem_wdata),
    .host_wstrb (mem_wstrb),
    .host_rdata (mem_rdata),
    .text       (text_bus),
    .heap       (heap_bus),
    .led        (led_bus)
  );

  heap_arbiter u_arbiter (
    .clk       (clk),
    .resetn    (resetn),
    .host      (heap_bus),
    .dma_req   (dma_req),
    .dma_grant (dma_grant),
    .dma_valid (dma_valid),
    .dma_ready (dma_ready),
    .dma_addr  (dma_addr),
    .dma_wdata (dma_wdata),
    .dma_wstrb (dma_wstrb),
    .dma_rdata (dma_rdata),
    .heap      (heap_ram_bus)
  );

  banked_ram text_ram (
    .clk    (clk),
    .resetn (resetn),
    .bus    (text_bus)
  );

  banked_ram heap_ram (
    .clk    (clk),
    .resetn (resetn),
    .bus    (heap_ram_bus)
  );

  led_port #(
    .LED_W (LED_W)
  ) u_led (
    .clk    (clk),
    .resetn (resetn),
    .bus    (led_bus),
    .led    (led)
  );

endmodule

// ==== logic/region_decoder.sv ====
`timescale 1ns/1ps

module region_decoder
  import bus_pkg::*;
  import soc_map_pkg::*;
(
  input  logic       host_valid,
  output logic       host_ready,
  input  addr_word_t host_addr,
  input  data_t      host_wdata,
  input  strb_t      host_wstrb,
  output data_t      host_rdata,
  mem_if.requester   text,
  mem_if.requester   heap,
  mem_if.requester   led
);

  logic sel_text;
  logic sel_heap;
  logic sel_led;

  assign sel_text = host_addr.region.code == REGION_TEXT;
  assign sel_heap = host_addr.region.code == REGION_HEAP;
  assign sel_led  = host_addr.region.code == REGION_LED;

  assign text.valid = host_valid && sel_text;
  assign heap.valid = host_valid && sel_heap;
  assign led.valid  = host_valid && sel_led;

  // Payload goes everywhere, valid picks the target
  assign text.addr  = host_addr;
  assign text.wdata = host_wdata;
  assign text.wstrb = host_wstrb;
  assign heap.addr  = host_addr;
  assign heap.wdata = host_wdata;
  assign heap.wstrb = host_wstrb;
  assign led.addr   = host_addr;
  assign led.wdata  = host_wdata;
  assign led.wstrb  = host_wstrb;

  // Unmapped regions never answer
  always_comb begin
    host_ready = 1'b0;
    host_rdata = '0;
    if (sel_text) begin
      host_ready = text.ready;
      host_rdata = text.rdata;
    end else if (sel_heap) begin
      host_ready = heap.ready;
      host_rdata = heap.rdata;
    end else if (sel_led) begin
      host_ready = led.ready;
      host_rdata = led.rdata;
    end
  end

endmodule

// ==== logic/led_port.sv ====
`timescale 1ns/1ps

module led_port
  import bus_pkg::*;
  import soc_map_pkg::*;
#(
  parameter int LED_W = LED_W_DEFAULT
) (
  input  logic             clk,
  input  logic             resetn,
  mem_if.target            bus,
  output logic [LED_W-1:0] led
);

  logic [LED_W-1:0] led_q;
  logic             ready_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      led_q   <= '0;
      ready_q <= 1'b0;
    end else begin
      // One ready pulse per request
      ready_q <= bus.valid && !ready_q;
      if (bus.valid && !ready_q && |bus.wstrb) begin
        led_q <= bus.wdata[LED_W-1:0];
      end
    end
  end

  assign bus.ready = ready_q;
  assign bus.rdata = DATA_W'(led_q);
  assign led       = led_q;

endmodule

// ==== logic/heap_arbiter.sv ====
`timescale 1ns/1ps

module heap_arbiter
  import bus_pkg::*;
(
  input  logic      clk,
  input  logic      resetn,
  mem_if.target     host,
  input  logic      dma_req,
  output logic      dma_grant,
  input  logic      dma_valid,
  output logic      dma_ready,
  input addr_word_t dma_addr,
  input  data_t     dma_wdata,
  input  strb_t     dma_wstrb,
  output data_t     dma_rdata,
  mem_if.requester  heap
);

  logic grant_q;
  logic host_busy_q;
  logic host_idle;

  // Host owns the heap from its first valid cycle until its ready
  assign host_idle = !host.valid && !host_busy_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      grant_q     <= 1'b0;
      host_busy_q <= 1'b0;
    end else begin
      host_busy_q <= host.valid && !grant_q && !heap.ready;
      if (!grant_q) begin
        if (dma_req && host_idle) begin
          grant_q <= 1'b1;
        end
      end else if (!dma_req) begin
        grant_q <= 1'b0;
      end
    end
  end

  // Heap port follows its owner
  assign heap.valid = grant_q ? dma_valid : host.valid;
  assign heap.addr  = grant_q ? dma_addr  : host.addr;
  assign heap.wdata = grant_q ? dma_wdata : host.wdata;
  assign heap.wstrb = grant_q ? dma_wstrb : host.wstrb;

  // Host waits here while the DMA port holds the heap
  assign host.ready = !grant_q && heap.ready;
  assign host.rdata = heap.rdata;

  assign dma_grant = grant_q;
  assign dma_ready = grant_q && heap.ready;
  assign dma_rdata = heap.rdata;

endmodule

// ==== logic/banked_ram.sv ====
`timescale 1ns/1ps

module banked_ram
  import bus_pkg::*;
(
  input logic   clk,
  input logic   resetn,
  mem_if.target bus
);

  data_t     dout [BANK_COUNT];
  data_t     read_q [BANK_COUNT];
  logic      valid_q;
  logic      new_req;
  logic      wr_ready;
  logic      rd_ready;
  bank_idx_t bank_d1;
  bank_idx_t bank_d2;

  for (genvar b = 0; b < BANK_COUNT; b++) begin : g_bank
    strb_t we;

    // Strobes only reach the addressed bank, and only once
    assign we = (bus.valid && !bus.ready && bus.addr.ram.bank == bank_idx_t'(b)) ?
                bus.wstrb : '0;

    bank_ram u_bank (
      .clk  (clk),
      .en   (bus.valid),
      .we   (we),
      .word (bus.addr.ram.word),
      .din  (bus.wdata),
      .dout (dout[b])
    );
  end

  // A request starts on the rising edge of valid
  assign new_req = bus.valid && !valid_q;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_q  <= 1'b0;
      wr_ready <= 1'b0;
      rd_ready <= 1'b0;
    end else begin
      valid_q  <= bus.valid;
      wr_ready <= new_req;
      rd_ready <= wr_ready;
    end
  end

  // Second read stage and its bank select
  always_ff @(posedge clk) begin
    read_q  <= dout;
    bank_d1 <= bus.addr.ram.bank;
    bank_d2 <= bank_d1;
  end

  // Writes finish after one cycle, reads after two
  assign bus.ready = bus.valid && ((|bus.wstrb) ? wr_ready : rd_ready);
  assign bus.rdata = read_q[bank_d2];

endmodule

// ==== logic/bank_ram.sv ====
`timescale 1ns/1ps

module bank_ram
  import bus_pkg::*;
(
  input  logic      clk,
  input  logic      en,
  input  strb_t     we,
  input  word_idx_t word,
  input  data_t     din,
  output data_t     dout
);

  for (genvar lane = 0; lane < STRB_W; lane++) begin : g_lane
    logic [7:0] mem [BANK_WORDS];
    logic [7:0] q;

    // Write-first per lane
    always_ff @(posedge clk) begin
      if (en) begin
        if (we[lane]) begin
          mem[word] <= din[8*lane +: 8];
          q <= din[8*lane +: 8];
        end else begin
          q <= mem[word];
        end
      end
    end

    assign dout[8*lane +: 8] = q;
  end

endmodule

// ==== logic/mem_if.sv ====
`timescale 1ns/1ps

interface mem_if;

  logic                valid;
  logic                ready;
  bus_pkg::addr_word_t addr;
  bus_pkg::data_t      wdata;
  bus_pkg::strb_t      wstrb;
  bus_pkg::data_t      rdata;

  modport requester (
    output valid, addr, wdata, wstrb,
    input  ready, rdata
  );

  modport target (
    input  valid, addr, wdata, wstrb,
    output ready, rdata
  );

endinterface

// ==== logic/soc_map_pkg.sv ====
package soc_map_pkg;

  // Upper 16 address bits of each target
  localparam logic [15:0] REGION_TEXT = 16'h0000;
  localparam logic [15:0] REGION_HEAP = 16'h0001;
  localparam logic [15:0] REGION_LED  = 16'h8001;

  localparam int LED_W_DEFAULT = 4;

endpackage

// ==== logic/bus_pkg.sv ====
package bus_pkg;

  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // 4 banks of 4K words make 64 KB
  localparam int BANK_COUNT = 4;
  localparam int BANK_WORDS = 4096;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;
  typedef logic [$clog2(BANK_COUNT)-1:0] bank_idx_t;
  typedef logic [$clog2(BANK_WORDS)-1:0] word_idx_t;

  // One bus address seen by region or by RAM location
  typedef union packed {
    struct packed {
      logic [15:0] code;
      logic [15:0] offset;
    } region;
    struct packed {
      logic [15:0] upper;
      bank_idx_t   bank;
      word_idx_t   word;
      logic [1:0]  byte_off;
    } ram;
  } addr_word_t;

endpackage
